//--- mm_pkg.sv
package mm_pkg;

    // Pegs per code, sets slot index width everywhere
    localparam int NUM_PEGS = 4;

    typedef logic [2:0] colour_t;              // One of eight colours

    // Slot 0 in the low bits
    typedef colour_t [NUM_PEGS-1:0] code_t;

    typedef logic [2:0] peg_count_t;           // 0 to NUM_PEGS
    typedef logic [3:0] score_t;               // Wraps at 16
    typedef logic [3:0] guess_count_t;
    typedef logic [6:0] seg_t;                 // Active low, bit 0 is segment a

    typedef struct packed {
        peg_count_t red;
        peg_count_t white;
    } feedback_t;

    // Red count that ends the round with a win
    localparam peg_count_t WIN_RED = peg_count_t'(NUM_PEGS);

    typedef enum logic [1:0] {
        ENTER_CODE,
        ENTER_GUESS,
        SCORING,
        ROUND_OVER
    } entry_state_t;

    typedef enum logic [1:0] {
        IDLE,
        RED_PASS,
        WHITE_PASS
    } scorer_state_t;

endpackage

//--- mm_entry_ctrl.sv
module mm_entry_ctrl (
    input  logic              clock,
    input  logic              resetn,
    input  mm_pkg::colour_t   colour_i,
    input  logic              enter_i,
    input  logic              new_round_i,
    input  logic              round_over_i,
    input  logic              result_valid_i,
    output logic              score_start_o,
    output mm_pkg::code_t     code_o,
    output mm_pkg::code_t     guess_o
);

    localparam int SLOT_W = $clog2(mm_pkg::NUM_PEGS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(mm_pkg::NUM_PEGS - 1);

    mm_pkg::entry_state_t state;
    logic [SLOT_W-1:0]    slot;
    logic                 restart;
    logic                 code_we;
    logic                 guess_we;

    // New round is dropped while a guess is being scored
    assign restart  = new_round_i && (state != mm_pkg::SCORING);
    assign code_we  = enter_i && !restart && (state == mm_pkg::ENTER_CODE);
    assign guess_we = enter_i && !restart && !round_over_i
                      && (state == mm_pkg::ENTER_GUESS);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state         <= mm_pkg::ENTER_CODE;
            slot          <= '0;
            score_start_o <= 1'b0;
        end else begin
            score_start_o <= 1'b0;
            if (restart) begin
                state <= mm_pkg::ENTER_CODE;
                slot  <= '0;
            end else begin
                case (state)
                    mm_pkg::ENTER_CODE: begin
                        if (code_we) begin
                            slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
                            if (slot == LAST_SLOT) begin
                                state <= mm_pkg::ENTER_GUESS;
                            end
                        end
                    end
                    mm_pkg::ENTER_GUESS: begin
                        // round_over_i lands one cycle after the final result
                        if (round_over_i) begin
                            state <= mm_pkg::ROUND_OVER;
                        end else if (guess_we) begin
                            slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
                            if (slot == LAST_SLOT) begin
                                state         <= mm_pkg::SCORING;
                                score_start_o <= 1'b1;
                            end
                        end
                    end
                    mm_pkg::SCORING: begin
                        if (result_valid_i) begin
                            state <= mm_pkg::ENTER_GUESS;
                        end
                    end
                    mm_pkg::ROUND_OVER: begin
                        state <= mm_pkg::ROUND_OVER;    // Held until new round
                    end
                endcase
            end
        end
    end

    // Peg registers
    always_ff @(posedge clock) begin
        if (restart) begin
            code_o  <= '0;
            guess_o <= '0;
        end else begin
            if (code_we) begin
                code_o[slot] <= colour_i;
            end
            if (guess_we) begin
                guess_o[slot] <= colour_i;
            end
        end
    end

    // Scorer answers only while a guess is pending
    a_result_in_scoring: assert property (
        @(posedge clock) disable iff (!resetn)
        result_valid_i |-> (state == mm_pkg::SCORING)
    );

endmodule

//--- mm_scorer.sv
module mm_scorer (
    input  logic                clock,
    input  logic                resetn,
    input  logic                start_i,
    input  logic                new_round_i,
    input  mm_pkg::code_t       code_i,
    input  mm_pkg::code_t       guess_i,
    output logic                result_valid_o,
    output mm_pkg::feedback_t   feedback_o
);

    localparam int SLOT_W = $clog2(mm_pkg::NUM_PEGS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(mm_pkg::NUM_PEGS - 1);

    mm_pkg::scorer_state_t       state;
    logic [SLOT_W-1:0]           slot;
    mm_pkg::code_t               code_q;
    mm_pkg::code_t               guess_q;
    logic [mm_pkg::NUM_PEGS-1:0] exact;
    logic [mm_pkg::NUM_PEGS-1:0] code_used;
    logic [mm_pkg::NUM_PEGS-1:0] guess_used;
    mm_pkg::peg_count_t          red_sum;
    mm_pkg::peg_count_t          red_q;
    mm_pkg::peg_count_t          white_q;
    logic                        take;
    logic [SLOT_W-1:0]           take_idx;
    logic                        last_visit;
    mm_pkg::feedback_t           result;
    mm_pkg::feedback_t           fb_q;

    always_comb begin
        red_sum = '0;
        for (int i = 0; i < mm_pkg::NUM_PEGS; i++) begin
            exact[i] = (code_q[i] == guess_q[i]);
            red_sum  = red_sum + mm_pkg::peg_count_t'(exact[i]);
        end
    end

    // Lowest free guess slot of the visited code colour
    always_comb begin
        take     = 1'b0;
        take_idx = '0;
        for (int j = mm_pkg::NUM_PEGS - 1; j >= 0; j--) begin
            if (!code_used[slot] && !guess_used[j] && (guess_q[j] == code_q[slot])) begin
                take     = 1'b1;
                take_idx = SLOT_W'(j);
            end
        end
    end

    assign last_visit     = (state == mm_pkg::WHITE_PASS) && (slot == LAST_SLOT);
    assign result.red     = red_q;
    assign result.white   = white_q + mm_pkg::peg_count_t'(take);
    assign result_valid_o = last_visit;
    assign feedback_o     = last_visit ? result : fb_q;

    always_ff @(posedge clock) begin
        if ((state == mm_pkg::IDLE) && start_i) begin
            code_q  <= code_i;
            guess_q <= guess_i;
        end
        if (state == mm_pkg::RED_PASS) begin
            code_used  <= exact;
            guess_used <= exact;
            red_q      <= red_sum;
            white_q    <= '0;
        end else if ((state == mm_pkg::WHITE_PASS) && take) begin
            guess_used[take_idx] <= 1'b1;
            white_q              <= white_q + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= mm_pkg::IDLE;
            slot  <= '0;
            fb_q  <= '0;
        end else begin
            case (state)
                mm_pkg::IDLE: begin
                    if (start_i) begin
                        state <= mm_pkg::RED_PASS;
                    end
                end
                mm_pkg::RED_PASS: begin
                    state <= mm_pkg::WHITE_PASS;
                    slot  <= '0;
                end
                mm_pkg::WHITE_PASS: begin
                    slot <= slot + 1'b1;            // One code slot per cycle
                    if (last_visit) begin
                        state <= mm_pkg::IDLE;
                    end
                end
                default: state <= mm_pkg::IDLE;
            endcase
            if (last_visit) begin
                fb_q <= result;
            end else if (new_round_i) begin
                fb_q <= '0;
            end
        end
    end

    a_peg_total: assert property (
        @(posedge clock) disable iff (!resetn)
        result_valid_o |-> ({1'b0, feedback_o.red} + {1'b0, feedback_o.white})
                           <= 4'(mm_pkg::NUM_PEGS)
    );

endmodule

//--- mm_scoreboard.sv
module mm_scoreboard #(
    parameter int MAX_GUESSES = 8
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                new_round_i,
    input  logic                result_valid_i,
    input  mm_pkg::feedback_t   feedback_i,
    output logic                round_over_o,
    output logic                setter_o,
    output mm_pkg::score_t      score_one_o,
    output mm_pkg::score_t      score_two_o
);

    mm_pkg::guess_count_t guess_cnt;
    mm_pkg::guess_count_t guess_next;
    logic                 win;
    logic                 out_of_guesses;

    assign guess_next     = guess_cnt + 1'b1;
    assign win            = (feedback_i.red == mm_pkg::WIN_RED);
    assign out_of_guesses = (guess_next == mm_pkg::guess_count_t'(MAX_GUESSES));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            guess_cnt    <= '0;
            round_over_o <= 1'b0;
            setter_o     <= 1'b0;       // Player one sets first
            score_one_o  <= '0;
            score_two_o  <= '0;
        end else if (new_round_i) begin
            // Roles swap, scores carry over
            guess_cnt    <= '0;
            round_over_o <= 1'b0;
            setter_o     <= ~setter_o;
        end else if (result_valid_i) begin
            guess_cnt <= guess_next;
            if (win || out_of_guesses) begin
                round_over_o <= 1'b1;
            end
            // Setter earns a point per missed guess
            if (!win) begin
                if (setter_o) begin
                    score_two_o <= score_two_o + 1'b1;
                end else begin
                    score_one_o <= score_one_o + 1'b1;
                end
            end
        end
    end

    // Entry side must stop scoring once the round is decided
    a_no_late_result: assert property (
        @(posedge clock) disable iff (!resetn)
        result_valid_i |-> !round_over_o
    );

endmodule

//--- mm_seg_decoder.sv
module mm_seg_decoder (
    input  logic [3:0]      digit_i,
    output mm_pkg::seg_t    seg_o
);

    // Active low, g in bit 6
    always_comb begin
        case (digit_i)
            4'h0: seg_o = 7'h40;
            4'h1: seg_o = 7'h79;
            4'h2: seg_o = 7'h24;
            4'h3: seg_o = 7'h30;
            4'h4: seg_o = 7'h19;
            4'h5: seg_o = 7'h12;
            4'h6: seg_o = 7'h02;
            4'h7: seg_o = 7'h78;
            4'h8: seg_o = 7'h00;
            4'h9: seg_o = 7'h18;
            4'hA: seg_o = 7'h08;
            4'hB: seg_o = 7'h03;
            4'hC: seg_o = 7'h46;
            4'hD: seg_o = 7'h21;
            4'hE: seg_o = 7'h06;
            4'hF: seg_o = 7'h0E;
        endcase
    end

endmodule

//--- mastermind_top.sv
module mastermind_top #(
    parameter int MAX_GUESSES = 8
) (
    input  logic                clock,
    input  logic                resetn,
    input  mm_pkg::colour_t     colour_i,
    input  logic                enter_i,
    input  logic                new_round_i,
    output mm_pkg::feedback_t   feedback_o,
    output logic                result_valid_o,
    output logic                round_over_o,
    output logic                setter_o,
    output mm_pkg::seg_t        seg_white_o,
    output mm_pkg::seg_t        seg_red_o,
    output mm_pkg::seg_t        seg_setter_o,
    output mm_pkg::seg_t        seg_score_two_o,
    output mm_pkg::seg_t        seg_score_one_o
);

    logic           score_start;
    mm_pkg::code_t  code;
    mm_pkg::code_t  guess;
    mm_pkg::score_t score_one;
    mm_pkg::score_t score_two;

    mm_entry_ctrl u_entry (
        .clock          (clock),
        .resetn         (resetn),
        .colour_i       (colour_i),
        .enter_i        (enter_i),
        .new_round_i    (new_round_i),
        .round_over_i   (round_over_o),
        .result_valid_i (result_valid_o),
        .score_start_o  (score_start),
        .code_o         (code),
        .guess_o        (guess)
    );

    mm_scorer u_scorer (
        .clock          (clock),
        .resetn         (resetn),
        .start_i        (score_start),
        .new_round_i    (new_round_i),
        .code_i         (code),
        .guess_i        (guess),
        .result_valid_o (result_valid_o),
        .feedback_o     (feedback_o)
    );

    mm_scoreboard #(
        .MAX_GUESSES    (MAX_GUESSES)
    ) u_board (
        .clock          (clock),
        .resetn         (resetn),
        .new_round_i    (new_round_i),
        .result_valid_i (result_valid_o),
        .feedback_i     (feedback_o),
        .round_over_o   (round_over_o),
        .setter_o       (setter_o),
        .score_one_o    (score_one),
        .score_two_o    (score_two)
    );

    // Digit displays
    mm_seg_decoder u_seg_white (.digit_i({1'b0, feedback_o.white}), .seg_o(seg_white_o));
    mm_seg_decoder u_seg_red (.digit_i({1'b0, feedback_o.red}), .seg_o(seg_red_o));
    mm_seg_decoder u_seg_setter (.digit_i({3'b000, setter_o}), .seg_o(seg_setter_o));
    mm_seg_decoder u_seg_score_two (.digit_i(score_two), .seg_o(seg_score_two_o));
    mm_seg_decoder u_seg_score_one (.digit_i(score_one), .seg_o(seg_score_one_o));

endmodule

//--- tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    input  logic reset_req_i,
    output logic clock,
    output logic resetn
);

    logic por_n;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        por_n <= 1'b1;
    end

    assign resetn = por_n && !reset_req_i;     // Power-on or requested reset

endmodule

//--- tb_mastermind.sv
module tb_mastermind;

    localparam int MAX_GUESSES    = 8;
    localparam int RESULT_TIMEOUT = 20;
    localparam int RESULT_LATENCY = 6;         // Counted from the edge that samples the last peg
    localparam mm_pkg::seg_t SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic              clock;
    logic              resetn;
    logic              reset_req;
    mm_pkg::colour_t   colour;
    logic              enter;
    logic              new_round;
    mm_pkg::feedback_t feedback;
    logic              result_valid;
    logic              round_over;
    logic              setter;
    mm_pkg::seg_t      seg_white;
    mm_pkg::seg_t      seg_red;
    mm_pkg::seg_t      seg_setter;
    mm_pkg::seg_t      seg_score_two;
    mm_pkg::seg_t      seg_score_one;

    int                value_errors;
    int                other_errors;
    integer            seed;
    mm_pkg::code_t     cur_code;
    mm_pkg::score_t    exp_one;
    mm_pkg::score_t    exp_two;
    logic              exp_setter;
    logic              exp_round_over;
    int                exp_guesses;

    tb_clock u_clock (.reset_req_i(reset_req), .clock(clock), .resetn(resetn));

    mastermind_top #(
        .MAX_GUESSES    (MAX_GUESSES)
    ) u_dut (
        .clock           (clock),
        .resetn          (resetn),
        .colour_i        (colour),
        .enter_i         (enter),
        .new_round_i     (new_round),
        .feedback_o      (feedback),
        .result_valid_o  (result_valid),
        .round_over_o    (round_over),
        .setter_o        (setter),
        .seg_white_o     (seg_white),
        .seg_red_o       (seg_red),
        .seg_setter_o    (seg_setter),
        .seg_score_two_o (seg_score_two),
        .seg_score_one_o (seg_score_one)
    );

    // Exact matches first and then each free code peg takes the lowest free guess peg
    function automatic mm_pkg::feedback_t ref_score(input mm_pkg::code_t code,
                                                    input mm_pkg::code_t guess);
        mm_pkg::feedback_t           fb;
        logic [mm_pkg::NUM_PEGS-1:0] code_used;
        logic [mm_pkg::NUM_PEGS-1:0] guess_used;
        logic                        found;
        fb         = '0;
        code_used  = '0;
        guess_used = '0;
        for (int i = 0; i < mm_pkg::NUM_PEGS; i++) begin
            if (code[i] == guess[i]) begin
                code_used[i]  = 1'b1;
                guess_used[i] = 1'b1;
                fb.red        = fb.red + 3'd1;
            end
        end
        for (int i = 0; i < mm_pkg::NUM_PEGS; i++) begin
            found = 1'b0;
            for (int j = 0; j < mm_pkg::NUM_PEGS; j++) begin
                if (!found && !code_used[i] && !guess_used[j] && (guess[j] == code[i])) begin
                    guess_used[j] = 1'b1;
                    found         = 1'b1;
                    fb.white      = fb.white + 3'd1;
                end
            end
        end
        return fb;
    endfunction

    function automatic mm_pkg::code_t random_code();
        mm_pkg::code_t c;
        for (int i = 0; i < mm_pkg::NUM_PEGS; i++) begin
            c[i] = mm_pkg::colour_t'($random(seed));
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic enter_pegs(input mm_pkg::code_t pegs);
        for (int i = 0; i < mm_pkg::NUM_PEGS; i++) begin
            @(posedge clock);
            enter  <= 1'b1;
            colour <= pegs[i];
        end
        @(posedge clock);
        enter  <= 1'b0;
        colour <= '0;
    endtask

    // Sampled at the falling edge away from register updates
    task automatic wait_result(output bit got, output int cycles);
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < RESULT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
            got = result_valid;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (resetn !== 1'b1 && n < 10) begin
            @(negedge clock);
            n++;
        end
        if (resetn !== 1'b1) begin
            $display("%0t: resetn stayed low", $time);
            other_errors++;
        end
    endtask

    task automatic check_board();
        if (round_over !== exp_round_over)
            report_mismatch("round_over_o", 32'(exp_round_over), 32'(round_over));
        if (setter !== exp_setter)
            report_mismatch("setter_o", 32'(exp_setter), 32'(setter));
        if (seg_setter !== SEG_TABLE[{3'b000, exp_setter}])
            report_mismatch("seg_setter_o", 32'(SEG_TABLE[{3'b000, exp_setter}]), 32'(seg_setter));
        if (seg_score_one !== SEG_TABLE[exp_one])
            report_mismatch("seg_score_one_o", 32'(SEG_TABLE[exp_one]), 32'(seg_score_one));
        if (seg_score_two !== SEG_TABLE[exp_two])
            report_mismatch("seg_score_two_o", 32'(SEG_TABLE[exp_two]), 32'(seg_score_two));
    endtask

    task automatic set_code(input mm_pkg::code_t code);
        enter_pegs(code);
        cur_code = code;
    endtask

    task automatic pulse_new_round();
        @(posedge clock);
        new_round <= 1'b1;
        @(posedge clock);
        new_round <= 1'b0;
        exp_setter     = !exp_setter;      // Roles swap
        exp_guesses    = 0;
        exp_round_over = 1'b0;
        @(negedge clock);
        if (feedback !== '0)
            report_mismatch("feedback_o", 32'd0, 32'(feedback));
        check_board();
    endtask

    task automatic start_round(input mm_pkg::code_t code);
        pulse_new_round();
        set_code(code);
    endtask

    task automatic play_guess(input mm_pkg::code_t guess);
        mm_pkg::feedback_t exp_fb;
        bit                got;
        int                cycles;
        exp_fb = ref_score(cur_code, guess);
        enter_pegs(guess);
        wait_result(got, cycles);
        if (!got) begin
            $display("%0t: no result_valid_o within %0d cycles of a guess", $time, cycles);
            other_errors++;
        end else begin
            if (cycles != RESULT_LATENCY)
                report_mismatch("result_valid_o latency", RESULT_LATENCY, cycles);
            if (feedback !== exp_fb)
                report_mismatch("feedback_o", 32'(exp_fb), 32'(feedback));
            if (seg_red !== SEG_TABLE[{1'b0, exp_fb.red}])
                report_mismatch("seg_red_o", 32'(SEG_TABLE[{1'b0, exp_fb.red}]), 32'(seg_red));
            if (seg_white !== SEG_TABLE[{1'b0, exp_fb.white}])
                report_mismatch("seg_white_o", 32'(SEG_TABLE[{1'b0, exp_fb.white}]),
                                32'(seg_white));
        end
        exp_guesses++;
        if (exp_fb.red != mm_pkg::peg_count_t'(mm_pkg::NUM_PEGS)) begin
            if (exp_setter)
                exp_two = exp_two + 4'd1;
            else
                exp_one = exp_one + 4'd1;
        end
        exp_round_over = (exp_fb.red == mm_pkg::peg_count_t'(mm_pkg::NUM_PEGS))
                         || (exp_guesses == MAX_GUESSES);
        @(negedge clock);
        check_board();
    endtask

    task automatic test_reset();
        wait_reset_release();
        @(negedge clock);
        if (feedback !== '0)
            report_mismatch("feedback_o", 32'd0, 32'(feedback));
        if (result_valid !== 1'b0)
            report_mismatch("result_valid_o", 32'd0, 32'(result_valid));
        if (seg_red !== SEG_TABLE[0])
            report_mismatch("seg_red_o", 32'(SEG_TABLE[0]), 32'(seg_red));
        if (seg_white !== SEG_TABLE[0])
            report_mismatch("seg_white_o", 32'(SEG_TABLE[0]), 32'(seg_white));
        check_board();
    endtask

    // Slot 3 is written first in each literal
    task automatic test_fixed_pairs();
        set_code({3'd3, 3'd2, 3'd1, 3'd1});
        play_guess({3'd1, 3'd1, 3'd2, 3'd1});
        play_guess({3'd1, 3'd1, 3'd3, 3'd2});
        play_guess({3'd1, 3'd1, 3'd1, 3'd1});
    endtask

    task automatic test_win();
        bit got;
        int cycles;
        play_guess(cur_code);
        enter_pegs(cur_code);          // Dropped since the round is over
        wait_result(got, cycles);
        if (got) begin
            $display("%0t: result_valid_o after the round had ended", $time);
            other_errors++;
        end
        check_board();
    endtask

    task automatic test_max_guesses();
        mm_pkg::score_t start_two;
        start_round({3'd4, 3'd5, 3'd6, 3'd7});
        start_two = exp_two;            // Player two sets this round
        for (int i = 0; i < MAX_GUESSES; i++) begin
            play_guess({3'd2, 3'd1, mm_pkg::colour_t'(i), 3'd7});
        end
        if (seg_score_two !== SEG_TABLE[4'(start_two + MAX_GUESSES)])
            report_mismatch("seg_score_two_o", 32'(SEG_TABLE[4'(start_two + MAX_GUESSES)]),
                            32'(seg_score_two));
        if (round_over !== 1'b1)
            report_mismatch("round_over_o", 32'd1, 32'(round_over));
    endtask

    task automatic test_new_round();
        pulse_new_round();
        start_round({3'd0, 3'd3, 3'd3, 3'd5});
        play_guess({3'd5, 3'd0, 3'd0, 3'd3});
        @(posedge clock);
        reset_req <= 1'b1;
        repeat (2) @(posedge clock);
        reset_req <= 1'b0;
        wait_reset_release();
        exp_one        = '0;
        exp_two        = '0;
        exp_setter     = 1'b0;
        exp_round_over = 1'b0;
        exp_guesses    = 0;
        @(negedge clock);
        check_board();
    endtask

    task automatic test_random();
        mm_pkg::code_t guess;
        for (int i = 0; i < 20; i++) begin
            if (i == 0 || exp_round_over)
                start_round(random_code());
            guess = (i % 5 == 4) ? cur_code : random_code();    // Regular wins end rounds
            play_guess(guess);
        end
    endtask

    initial begin
        colour         = '0;
        enter          = 1'b0;
        new_round      = 1'b0;
        reset_req      = 1'b0;
        seed           = 32'h538a;
        value_errors   = 0;
        other_errors   = 0;
        cur_code       = '0;
        exp_one        = '0;
        exp_two        = '0;
        exp_setter     = 1'b0;
        exp_round_over = 1'b0;
        exp_guesses    = 0;
        test_reset();
        test_fixed_pairs();
        test_win();
        test_max_guesses();
        test_new_round();
        test_random();
        $display("value mismatches: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
mm_pkg.sv
mm_entry_ctrl.sv
mm_scorer.sv
mm_scoreboard.sv
mm_seg_decoder.sv
mastermind_top.sv
tb_clock.sv
tb_mastermind.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_mastermind
FILELIST    = tb.f
OBJ_DIR     = obj_dir
LOG         = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
